/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -j 0 \
	--top-module tb_tmu2_dest_path -f vlog.f -o sim_tb \
	&& ./obj_dir/sim_tb | grep "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* src/tmu2_blend.sv */
`timescale 1ns/1ns
`default_nettype none
// ############################
// Alpha blend, two stages.
// Mixes source and destination RGB565 per channel.
// ############################

module tmu2_blend (
	input  wire                               sys_clk,
	input  wire                               sys_rst,

	input  wire  [tmu2_pkg::alpha_width-1:0]  alpha_i,
	output logic                              fetch_en_o,
	input  wire                               busy_i,
	output logic                              busy_o,

	input  wire                               pipe_stb_i,
	output logic                              pipe_ack_o,
	input  wire  [15:0]                       color_i,
	input  wire  [tmu2_pkg::dadr_width-1:0]   dadr_i,
	input  wire  [15:0]                       dcolor_i,

	output logic                              out_stb_o,
	input  wire                               out_ack_i,
	output logic [15:0]                       out_color_o,
	output logic [tmu2_pkg::dadr_width-1:0]   out_dadr_o
);
	import tmu2_pkg::*;

	logic                    stall;
	logic [alpha_width-1:0]  inv_alpha;

	// stage one registers.
	logic                    s1_valid;
	logic [dadr_width-1:0]   s1_dadr;
	logic [10:0]             s1_rs;
	logic [10:0]             s1_rd;
	logic [11:0]             s1_gs;
	logic [11:0]             s1_gd;
	logic [10:0]             s1_bs;
	logic [10:0]             s1_bd;

	// stage two arithmetic.
	logic [10:0]             r_sum;
	logic [11:0]             g_sum;
	logic [10:0]             b_sum;
	logic [4:0]              r_q;
	logic [5:0]              g_q;
	logic [4:0]              b_q;

	assign fetch_en_o = (alpha_i != alpha_width'(alpha_max)); // opaque needs no dest.
	assign inv_alpha  = alpha_width'(alpha_max) - alpha_i;

	assign stall      = out_stb_o & ~out_ack_i; // hold the whole pipe.
	assign pipe_ack_o = ~stall;
	assign busy_o     = busy_i | s1_valid | out_stb_o;

	// ############################
	// stage one, weighted products
	// ############################
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid <= 1'b0;
		end else if (~stall) begin
			s1_valid <= pipe_stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (~stall & pipe_stb_i) begin
			s1_dadr <= dadr_i;
			s1_rs   <= 11'(color_i[15:11]) * 11'(alpha_i);
			s1_rd   <= 11'(dcolor_i[15:11]) * 11'(inv_alpha);
			s1_gs   <= 12'(color_i[10:5]) * 12'(alpha_i);
			s1_gd   <= 12'(dcolor_i[10:5]) * 12'(inv_alpha);
			s1_bs   <= 11'(color_i[4:0]) * 11'(alpha_i);
			s1_bd   <= 11'(dcolor_i[4:0]) * 11'(inv_alpha);
		end
	end

	// ############################
	// stage two, sum and divide
	// ############################
	assign r_sum = s1_rs + s1_rd; // at most 31 * 63.
	assign g_sum = s1_gs + s1_gd; // at most 63 * 63.
	assign b_sum = s1_bs + s1_bd;

	assign r_q = 5'(r_sum / 11'(alpha_max));
	assign g_q = 6'(g_sum / 12'(alpha_max));
	assign b_q = 5'(b_sum / 11'(alpha_max));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			out_stb_o <= 1'b0;
		end else if (~stall) begin
			out_stb_o <= s1_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (~stall & s1_valid) begin
			out_color_o <= {r_q, g_q, b_q}; // back to RGB565.
			out_dadr_o  <= s1_dadr;
		end
	end

	// a stalled result does not move.
	a_out_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb_o && !out_ack_i |=>
			out_stb_o && $stable(out_color_o) && $stable(out_dadr_o));

endmodule

`default_nettype wire

/* src/tmu2_dest_path.sv */
`timescale 1ns/1ns
`default_nettype none
// ############################
// TMU destination path top.
// Fetch cache followed by the alpha blend.
// ############################

module tmu2_dest_path (
	input  wire                               sys_clk,
	input  wire                               sys_rst,

	input  wire  [tmu2_pkg::alpha_width-1:0]  alpha_i,
	input  wire                               flush_i,
	output logic                              busy_o,

	input  wire                               pix_stb_i,
	output logic                              pix_ack_o,
	input  wire  [15:0]                       color_i,
	input  wire  [tmu2_pkg::dadr_width-1:0]   dadr_i,

	output logic [tmu2_pkg::fml_depth-1:0]    fml_adr_o,
	output logic                              fml_stb_o,
	input  wire                               fml_ack_i,
	input  wire  [63:0]                       fml_di_i,

	output logic                              out_stb_o,
	input  wire                               out_ack_i,
	output logic [15:0]                       out_color_o,
	output logic [tmu2_pkg::dadr_width-1:0]   out_dadr_o
);
	import tmu2_pkg::*;

	logic                   fetch_en;
	logic                   fdest_busy;
	logic                   stb_f;    // cache to blend.
	logic                   ack_f;
	logic [15:0]            color_f;
	logic [dadr_width-1:0]  dadr_f;
	logic [15:0]            dcolor;

	tmu2_fdest u_fdest (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.fml_adr_o  (fml_adr_o),
		.fml_stb_o  (fml_stb_o),
		.fml_ack_i  (fml_ack_i),
		.fml_di_i   (fml_di_i),
		.flush_i    (flush_i),
		.busy_o     (fdest_busy),
		.fetch_en_i (fetch_en),
		.pipe_stb_i (pix_stb_i),
		.pipe_ack_o (pix_ack_o),
		.color_i    (color_i),
		.dadr_i     (dadr_i),
		.pipe_stb_o (stb_f),
		.pipe_ack_i (ack_f),
		.color_f_o  (color_f),
		.dadr_f_o   (dadr_f),
		.dcolor_o   (dcolor)
	);

	tmu2_blend u_blend (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.alpha_i     (alpha_i),
		.fetch_en_o  (fetch_en),
		.busy_i      (fdest_busy),
		.busy_o      (busy_o),
		.pipe_stb_i  (stb_f),
		.pipe_ack_o  (ack_f),
		.color_i     (color_f),
		.dadr_i      (dadr_f),
		.dcolor_i    (dcolor),
		.out_stb_o   (out_stb_o),
		.out_ack_i   (out_ack_i),
		.out_color_o (out_color_o),
		.out_dadr_o  (out_dadr_o)
	);

endmodule

`default_nettype wire

/* src/tmu2_fdest.sv */
`timescale 1ns/1ns
`default_nettype none
// ############################
// Destination fetch cache.
// Holds one framebuffer line and reads misses as a four-beat burst.
// ############################

module tmu2_fdest (
	input  wire                              sys_clk,
	input  wire                              sys_rst,

	output logic [tmu2_pkg::fml_depth-1:0]   fml_adr_o,
	output logic                             fml_stb_o,
	input  wire                              fml_ack_i,
	input  wire  [63:0]                      fml_di_i,

	input  wire                              flush_i,
	output logic                             busy_o,
	input  wire                              fetch_en_i,

	input  wire                              pipe_stb_i,
	output logic                             pipe_ack_o,
	input  wire  [15:0]                      color_i,
	input  wire  [tmu2_pkg::dadr_width-1:0]  dadr_i,

	output logic                             pipe_stb_o,
	input  wire                              pipe_ack_i,
	output logic [15:0]                      color_f_o,
	output logic [tmu2_pkg::dadr_width-1:0]  dadr_f_o,
	output logic [15:0]                      dcolor_o
);
	import tmu2_pkg::*;

	logic                          accept;
	logic                          wanted;   // a pixel sits in the output register.
	logic [dadr_width-1:0]         dadr_r;
	logic                          valid;
	logic [tag_width-1:0]          tag;
	logic                          tag_match;
	logic                          tag_we;
	logic                          hit;

	fml_word_u                     storage [0:burst_len-1];
	fml_word_u                     storage_do;
	logic [$clog2(burst_len)-1:0]  storage_wa;
	logic                          storage_we;

	logic [2:0]                    state;
	logic [2:0]                    next_state;
	logic                          stb_after_fetch;

	// ############################
	// hit detection
	// ############################
	assign accept = pipe_stb_i & pipe_ack_o;
	assign hit    = valid & tag_match; // flush also kills a pending hit.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid <= 1'b0;
		end else if (flush_i) begin
			valid <= 1'b0;
		end else if (tag_we) begin
			valid <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tag_match <= 1'b0;
		end else if (accept) begin
			tag_match <= (dadr_i[dadr_width-1:4] == tag);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tag_we) begin
			tag <= dadr_r[dadr_width-1:4];
		end
	end

	// forwarded pixel.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			dadr_r    <= dadr_i;
			color_f_o <= color_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wanted <= 1'b0;
		end else if (pipe_ack_o) begin
			wanted <= pipe_stb_i;
		end
	end

	assign dadr_f_o = dadr_r;
	assign busy_o   = wanted;

	// ############################
	// line storage
	// ############################
	always_ff @(posedge sys_clk) begin
		if (storage_we) begin
			storage[storage_wa].raw <= fml_di_i;
		end
	end

	assign storage_do = storage[dadr_r[3:2]];         // word within the line.
	assign dcolor_o   = storage_do.pix[dadr_r[1:0]];  // pixel within the word.

	// ############################
	// burst controller
	// ############################
	assign fml_adr_o = {dadr_r[dadr_width-1:4], 5'd0};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= fd_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state      = state;
		tag_we          = 1'b0;
		storage_we      = 1'b0;
		storage_wa      = '0;
		fml_stb_o       = 1'b0;
		pipe_ack_o      = 1'b0;
		stb_after_fetch = 1'b0;
		case (state)
			fd_idle: begin
				pipe_ack_o = pipe_ack_i | ~wanted;
				if (wanted & ~hit & fetch_en_i) begin
					pipe_ack_o = 1'b0; // stall input during the miss.
					next_state = fd_fetch1;
				end
			end
			fd_fetch1: begin
				fml_stb_o = 1'b1;
				if (fml_ack_i) begin
					storage_we = 1'b1; // first beat comes with the ack.
					storage_wa = 2'd0;
					next_state = fd_fetch2;
				end
			end
			fd_fetch2: begin
				storage_we = 1'b1;
				storage_wa = 2'd1;
				next_state = fd_fetch3;
			end
			fd_fetch3: begin
				storage_we = 1'b1;
				storage_wa = 2'd2;
				next_state = fd_fetch4;
			end
			fd_fetch4: begin
				storage_we = 1'b1;
				storage_wa = 2'd3;
				tag_we     = 1'b1;
				next_state = fd_out;
			end
			fd_out: begin
				stb_after_fetch = 1'b1;
				pipe_ack_o      = pipe_ack_i;
				if (pipe_ack_i) begin
					next_state = fd_idle;
				end
			end
			default: begin
				next_state = fd_idle;
			end
		endcase
	end

	assign pipe_stb_o = stb_after_fetch
		| ((state == fd_idle) & wanted & (hit | ~fetch_en_i));

	// ############################
	// checks
	// ############################
	a_fml_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fml_stb_o && !fml_ack_i |=> fml_stb_o);

	// no pixel leaves on the ack cycle or the three beats after it.
	a_no_out_in_fetch: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(fml_stb_o && fml_ack_i) || $past(fml_stb_o && fml_ack_i, 1)
			|| $past(fml_stb_o && fml_ack_i, 2) || $past(fml_stb_o && fml_ack_i, 3)
			|-> !pipe_stb_o);

endmodule

`default_nettype wire

/* src/tmu2_pkg.sv */
`default_nettype none
// ############################
// TMU destination path package.
// Bus widths, blend constants, FSM codes and the burst word.
// ############################

package tmu2_pkg;

	// ############################
	// memory bus and addressing
	// ############################
	localparam int fml_depth  = 26;             // byte address width.
	localparam int dadr_width = fml_depth - 1;  // in 16-bit words.
	localparam int tag_width  = dadr_width - 4; // one line is 16 pixels.
	localparam int burst_len  = 4;              // beats per line.

	// ############################
	// blending
	// ############################
	localparam int alpha_width = 6;
	localparam int alpha_max   = 63;            // fully opaque.

	// fetch controller states.
	localparam logic [2:0] fd_idle   = 3'd0;
	localparam logic [2:0] fd_fetch1 = 3'd1;
	localparam logic [2:0] fd_fetch2 = 3'd2;
	localparam logic [2:0] fd_fetch3 = 3'd3;
	localparam logic [2:0] fd_fetch4 = 3'd4;
	localparam logic [2:0] fd_out    = 3'd5;

	// One 64-bit burst beat. The bus delivers it as a raw word, and the
	// cache reads it back as four RGB565 pixels, pixel 0 in the top bits.
	typedef union packed {
		logic [63:0]       raw;
		logic [0:3][15:0]  pix;
	} fml_word_u;

endpackage

`default_nettype wire

/* testbench/tb_common.svh */
// ############################
// Testbench helpers.
// Xorshift generator and the memory content rule.
// ############################

// 64-bit xorshift step.
function automatic logic [63:0] xorshift64(input logic [63:0] x);
	logic [63:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 7);
	y = y ^ (y << 17);
	return y;
endfunction

// one beat of a framebuffer line, mixed from the full address.
function automatic logic [63:0] mem_word(input logic [63:0] line, input int beat);
	return xorshift64((line << 2) + 64'(beat));
endfunction

/* testbench/fml_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none
// ############################
// Memory bus responder.
// Random ack delay, then four beats.
// ############################

module fml_mem_model (
	input  wire                             sys_clk,
	input  wire                             sys_rst,
	input  wire  [tmu2_pkg::fml_depth-1:0]  fml_adr_i,
	input  wire                             fml_stb_i,
	output logic                            fml_ack_o,
	output logic [63:0]                     fml_di_o
);
	import tmu2_pkg::*;
	`include "tb_common.svh"

	logic [63:0]           rng      = 64'd29241 ^ 64'h5bd1e995;
	logic                  ack_r    = 1'b0;
	logic [63:0]           di_r     = 64'd0;
	logic [tag_width-1:0]  line_r   = '0;
	logic [2:0]            beat     = 3'd0;  // beat about to be driven.
	logic                  pending  = 1'b0;
	logic [1:0]            wait_cnt = 2'd0;

	assign fml_ack_o = ack_r;
	assign fml_di_o  = di_r;

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			ack_r   <= 1'b0;
			di_r    <= 64'd0;
			beat    <= 3'd0;
			pending <= 1'b0;
		end else if (beat != 3'd0) begin
			ack_r <= 1'b0;
			if (beat == 3'd4) begin
				di_r <= 64'd0;
				beat <= 3'd0;
			end else begin
				di_r <= mem_word(64'(line_r), int'(beat));
				beat <= beat + 3'd1;
			end
		end else if (pending) begin
			if (wait_cnt == 2'd0) begin
				ack_r   <= 1'b1; // first beat rides on the ack.
				di_r    <= mem_word(64'(line_r), 0);
				beat    <= 3'd1;
				pending <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end else if (fml_stb_i) begin
			rng    = xorshift64(rng);
			line_r <= fml_adr_i[fml_depth-1:5];
			if (rng[1:0] == 2'd0) begin
				ack_r <= 1'b1; // no extra delay.
				di_r  <= mem_word(64'(fml_adr_i[fml_depth-1:5]), 0);
				beat  <= 3'd1;
			end else begin
				pending  <= 1'b1;
				wait_cnt <= rng[1:0] - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_tmu2_dest_path.sv */
`timescale 1ns/1ns
`default_nettype none
// ############################
// Testbench for the destination path.
// Random pixels against a cache and blend model.
// ############################

module tb_tmu2_dest_path;
	import tmu2_pkg::*;
	`include "tb_common.svh"

	localparam int seed         = 29241;
	localparam int accept_limit = 300;   // cycles per pixel.
	localparam int drain_limit  = 3000;

	logic                    sys_clk;
	logic                    sys_rst   = 1'b1;
	logic [alpha_width-1:0]  alpha_i   = '0;
	logic                    flush_i   = 1'b0;
	logic                    busy_o;
	logic                    pix_stb_i = 1'b0;
	logic                    pix_ack_o;
	logic [15:0]             color_i   = 16'd0;
	logic [dadr_width-1:0]   dadr_i    = '0;
	logic [fml_depth-1:0]    fml_adr_o;
	logic                    fml_stb_o;
	logic                    fml_ack_i;
	logic [63:0]             fml_di_i;
	logic                    out_stb_o;
	logic                    out_ack_i = 1'b0;
	logic [15:0]             out_color_o;
	logic [dadr_width-1:0]   out_dadr_o;

	// ############################
	// reference model state
	// ############################
	logic [63:0]             rng = 64'(seed);
	logic                    m_valid = 1'b0;
	logic [tag_width-1:0]    m_tag = '0;
	logic [63:0]             m_line [0:burst_len-1];
	int                      m_alpha = 0;
	int                      miss_count = 0;
	int                      burst_count = 0;
	int                      bursts_before;
	logic                    opaque = 1'b0;
	logic [dadr_width-1:0]   last_dadr = '0;
	logic [15:0]             exp_color_q [$];
	logic [dadr_width-1:0]   exp_dadr_q [$];
	logic [tag_width-1:0]    exp_line_q [$];
	logic                    stalled = 1'b0;
	logic [15:0]             held_color;
	logic [dadr_width-1:0]   held_dadr;

	tmu2_dest_path dut (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.alpha_i     (alpha_i),
		.flush_i     (flush_i),
		.busy_o      (busy_o),
		.pix_stb_i   (pix_stb_i),
		.pix_ack_o   (pix_ack_o),
		.color_i     (color_i),
		.dadr_i      (dadr_i),
		.fml_adr_o   (fml_adr_o),
		.fml_stb_o   (fml_stb_o),
		.fml_ack_i   (fml_ack_i),
		.fml_di_i    (fml_di_i),
		.out_stb_o   (out_stb_o),
		.out_ack_i   (out_ack_i),
		.out_color_o (out_color_o),
		.out_dadr_o  (out_dadr_o)
	);

	fml_mem_model memory (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.fml_adr_i (fml_adr_o),
		.fml_stb_i (fml_stb_o),
		.fml_ack_o (fml_ack_i),
		.fml_di_o  (fml_di_i)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	function automatic logic [63:0] next_rand();
		rng = xorshift64(rng);
		return rng;
	endfunction

	// per channel mix, rounding down.
	function automatic logic [15:0] blend_ref(logic [15:0] s, logic [15:0] d, int a);
		int r;
		int g;
		int b;
		r = (int'(s[15:11]) * a + int'(d[15:11]) * (alpha_max - a)) / alpha_max;
		g = (int'(s[10:5]) * a + int'(d[10:5]) * (alpha_max - a)) / alpha_max;
		b = (int'(s[4:0]) * a + int'(d[4:0]) * (alpha_max - a)) / alpha_max;
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	// mostly a handful of lines, sometimes anywhere.
	function automatic logic [dadr_width-1:0] pick_dadr();
		logic [63:0]           r;
		logic [tag_width-1:0]  line;
		r = next_rand();
		if (r[2:0] == 3'd0) begin
			line = r[40:20];
		end else begin
			line = 21'h0a5c0 + 21'(r[9:8]);
		end
		return {line, r[15:12]};
	endfunction

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	// ############################
	// stimulus
	// ############################
	task automatic send_pixel(logic [15:0] col, logic [dadr_width-1:0] adr);
		int                    waited;
		logic [tag_width-1:0]  line;
		logic [63:0]           word;
		logic [15:0]           dst;
		pix_stb_i <= 1'b1;
		color_i   <= col;
		dadr_i    <= adr;
		waited = 0;
		do begin
			@(posedge sys_clk);
			waited++;
			if (waited > accept_limit) stop_run("timeout: pixel never accepted");
		end while (!pix_ack_o);
		line = adr[dadr_width-1:4];
		if (m_alpha != alpha_max) begin
			if (!m_valid || m_tag != line) begin
				exp_line_q.push_back(line); // line refill.
				miss_count++;
				m_valid = 1'b1;
				m_tag   = line;
				for (int b = 0; b < burst_len; b++) m_line[b] = mem_word(64'(line), b);
			end
			word = m_line[adr[3:2]];
			dst  = word[(3 - int'(adr[1:0])) * 16 +: 16];
			exp_color_q.push_back(blend_ref(col, dst, m_alpha));
		end else begin
			exp_color_q.push_back(col);
		end
		exp_dadr_q.push_back(adr);
		last_dadr = adr;
	endtask

	task automatic drain();
		int waited;
		pix_stb_i <= 1'b0;
		waited = 0;
		while (busy_o || exp_color_q.size() != 0) begin
			@(posedge sys_clk);
			waited++;
			if (waited > drain_limit) stop_run("timeout: pipeline did not drain");
		end
		check_value("fml burst count", 64'(burst_count), 64'(miss_count));
	endtask

	task automatic run_batch(int alpha, int count);
		alpha_i <= 6'(alpha);
		m_alpha = alpha;
		opaque  = (alpha == alpha_max);
		@(posedge sys_clk);
		for (int i = 0; i < count; i++) begin
			if (next_rand() % 4 == 0) begin
				pix_stb_i <= 1'b0; // idle gap.
				@(posedge sys_clk);
			end
			send_pixel(16'(next_rand()), pick_dadr());
		end
		drain();
		opaque = 1'b0;
	endtask

	// ############################
	// monitors
	// ############################
	always @(posedge sys_clk) begin
		out_ack_i <= (next_rand() % 3 != 0);
	end

	always @(posedge sys_clk) begin
		if (!sys_rst) begin
			if (stalled) begin
				check_value("out_stb_o", 64'(out_stb_o), 64'd1);
				check_value("out_color_o", 64'(out_color_o), 64'(held_color));
				check_value("out_dadr_o", 64'(out_dadr_o), 64'(held_dadr));
			end
			if (out_stb_o) begin
				check_value("busy_o", 64'(busy_o), 64'd1); // a pixel is held.
			end
			if (out_stb_o && out_ack_i) begin
				if (exp_color_q.size() == 0) stop_run("output pixel with none expected");
				check_value("out_color_o", 64'(out_color_o), 64'(exp_color_q.pop_front()));
				check_value("out_dadr_o", 64'(out_dadr_o), 64'(exp_dadr_q.pop_front()));
			end
			stalled    = out_stb_o && !out_ack_i;
			held_color = out_color_o;
			held_dadr  = out_dadr_o;
		end
	end

	always @(posedge sys_clk) begin
		if (!sys_rst && fml_stb_o && fml_ack_i) begin
			if (exp_line_q.size() == 0) stop_run("fml burst with no miss expected");
			check_value("fml_adr_o", 64'(fml_adr_o), 64'({exp_line_q.pop_front(), 5'd0}));
			burst_count++;
		end
		if (opaque && fml_stb_o) stop_run("fml_stb_o rose while alpha is opaque");
	end

	// ############################
	// main sequence
	// ############################
	initial begin
		repeat (2) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		check_value("out_stb_o", 64'(out_stb_o), 64'd0);
		check_value("fml_stb_o", 64'(fml_stb_o), 64'd0);
		check_value("busy_o", 64'(busy_o), 64'd0);

		for (int k = 0; k < 3; k++) run_batch(int'(next_rand() % 63), 40);

		// flush, then the same line again.
		flush_i <= 1'b1;
		@(posedge sys_clk);
		flush_i <= 1'b0;
		m_valid = 1'b0;
		bursts_before = burst_count;
		send_pixel(16'(next_rand()), last_dadr);
		drain();
		check_value("bursts after flush", 64'(burst_count), 64'(bursts_before + 1));

		run_batch(alpha_max, 30);
		run_batch(int'(next_rand() % 63), 30);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
src/tmu2_pkg.sv
src/tmu2_fdest.sv
src/tmu2_blend.sv
src/tmu2_dest_path.sv
testbench/fml_mem_model.sv
testbench/tb_tmu2_dest_path.sv
